//--- common/definitions.sv
package definitions;

    // architectural register index, x0..x31
    typedef logic [4:0] regName_t;

    // native data word of the integer pipeline
    typedef logic [31:0] word_t;

    // byte address as produced by the ALU
    typedef logic [31:0] addr_t;

    // hardwired zero register
    localparam regName_t zero = 5'd0;

endpackage

//--- common/pipeline_pkg.sv
package pipeline_pkg;

    import definitions::*;

    // execute stage result handed to the memory stage
    typedef struct packed {
        logic     valid;
        logic     reg_write;
        logic     mem_to_reg;
        logic     mem_read;
        logic     mem_write;
        // ALU result, or the byte address for loads and stores
        word_t    alu_out;
        word_t    store_data;
        regName_t rd;
    } ex_mem_t;

    // payload crossing the MEM/WB boundary
    typedef struct packed {
        logic     reg_write;
        logic     mem_to_reg;
        word_t    read_data;
        word_t    alu_out;
        regName_t rd;
    } mem_wb_t;

    // command held stable while a data memory request is up
    typedef struct packed {
        logic  write;
        addr_t addr;
        word_t wdata;
    } dmem_req_t;

    // one retired instruction, as seen at the top level
    typedef struct packed {
        logic     valid;
        regName_t rd;
        word_t    data;
    } commit_t;

endpackage

//--- memory/mem_stage.sv
`timescale 1ns/100ps

module mem_stage
    import definitions::*;
    import pipeline_pkg::*;
(
    input  logic      clk,
    input  logic      rstN,
    input  ex_mem_t   ex_in,
    input  logic      dmem_ack,
    input  word_t     dmem_rdata,
    output logic      ex_ready,
    output logic      dmem_req,
    output dmem_req_t dmem_cmd,
    output mem_wb_t   mem_wb_in,
    output logic      mem_read,
    output logic      mem_ready
);

    // releasing waits for ack to drop before the next request may start
    typedef enum logic [1:0] {
        idle,
        request,
        releasing
    } mem_state_t;

    mem_state_t state, state_next;
    logic       accept;
    logic       mem_op;
    logic       is_load;
    logic       pend_load;
    logic       pend_reg_write;
    logic       pend_mem_to_reg;
    regName_t   pend_rd;
    dmem_req_t  cmd_q;

    assign ex_ready = (state == idle);
    assign accept   = ex_in.valid && ex_ready;
    assign mem_op   = ex_in.mem_read || ex_in.mem_write;
    // a write wins if both flags are set
    assign is_load  = ex_in.mem_read && !ex_in.mem_write;

    assign dmem_req = (state == request);
    assign dmem_cmd = cmd_q;

    assign mem_read  = accept && is_load;
    assign mem_ready = (state == request) && dmem_ack && pend_load;

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (accept && mem_op) begin
                    state_next = request;
                end
            end
            request: begin
                if (dmem_ack) begin
                    state_next = releasing;
                end
            end
            releasing: begin
                if (!dmem_ack) begin
                    state_next = idle;
                end
            end
            default: state_next = idle;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= idle;
            pend_load <= 1'b0;
        end else begin
            state <= state_next;
            if (accept && mem_op) begin
                pend_load <= is_load;
            end
        end
    end

    // command and destination of the access in flight
    always_ff @(posedge clk) begin
        if (accept && mem_op) begin
            cmd_q.write     <= ex_in.mem_write;
            cmd_q.addr      <= ex_in.alu_out;
            cmd_q.wdata     <= ex_in.store_data;
            pend_reg_write  <= ex_in.reg_write;
            pend_mem_to_reg <= ex_in.mem_to_reg;
            pend_rd         <= ex_in.rd;
        end
    end

    always_comb begin
        // bubble by default
        mem_wb_in.reg_write  = 1'b0;
        mem_wb_in.mem_to_reg = 1'b0;
        mem_wb_in.read_data  = '0;
        mem_wb_in.alu_out    = '0;
        mem_wb_in.rd         = zero;
        if ((accept && !mem_op) || mem_read) begin
            mem_wb_in.reg_write  = ex_in.reg_write;
            mem_wb_in.mem_to_reg = ex_in.mem_to_reg;
            mem_wb_in.alu_out    = ex_in.alu_out;
            mem_wb_in.rd         = ex_in.rd;
        end else if (mem_ready) begin
            mem_wb_in.reg_write  = pend_reg_write;
            mem_wb_in.mem_to_reg = pend_mem_to_reg;
            mem_wb_in.read_data  = dmem_rdata;
            mem_wb_in.alu_out    = cmd_q.addr;
            mem_wb_in.rd         = pend_rd;
        end
    end

endmodule

//--- memory/data_memory.sv
`timescale 1ns/100ps

module data_memory
    import definitions::*;
    import pipeline_pkg::*;
#(
    parameter int MEM_DEPTH = 256,
    parameter int MEM_WAIT  = 3
)(
    input  logic      clk,
    input  logic      rstN,
    input  logic      dmem_req,
    input  dmem_req_t dmem_cmd,
    output logic      dmem_ack,
    output word_t     dmem_rdata
);

    localparam int IDX_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;
    localparam int CNT_W = (MEM_WAIT > 0) ? $clog2(MEM_WAIT + 1) : 1;

    // word index into the array
    typedef logic [IDX_W-1:0] mem_idx_t;

    word_t            mem [MEM_DEPTH];
    logic [CNT_W-1:0] wait_cnt;
    mem_idx_t         idx;
    logic             done;

    // byte address to word index, wrapping at the array size
    assign idx = mem_idx_t'(dmem_cmd.addr[31:2] % MEM_DEPTH);

    // wait period over, answer on the next edge
    assign done = dmem_req && !dmem_ack && (wait_cnt == CNT_W'(MEM_WAIT));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
            dmem_ack   <= 1'b0;
            dmem_rdata <= '0;
            wait_cnt   <= '0;
        end else if (!dmem_req) begin
            // requester has let go, close the handshake
            dmem_ack <= 1'b0;
            wait_cnt <= '0;
        end else if (done) begin
            dmem_ack   <= 1'b1;
            wait_cnt   <= '0;
            dmem_rdata <= mem[idx];
            if (dmem_cmd.write) begin
                mem[idx] <= dmem_cmd.wdata;
            end
        end else if (!dmem_ack) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

endmodule

//--- source/mem_wb_register.sv
`timescale 1ns/100ps

module mem_wb_register
    import definitions::*;
    import pipeline_pkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  mem_wb_t mem_wb_in,
    input  logic    mem_read,
    input  logic    mem_ready,
    output mem_wb_t mem_wb_out
);

    typedef enum logic {
        mem_read_idle,
        mem_reading
    } rd_state_t;

    rd_state_t state, state_next;
    regName_t  hold_rd, hold_rd_next;
    regName_t  next_rd;
    logic      hold_mem_to_reg, hold_mem_to_reg_next;
    logic      next_mem_to_reg;

    always_comb begin
        state_next           = state;
        next_rd              = mem_wb_in.rd;
        next_mem_to_reg      = mem_wb_in.mem_to_reg;
        hold_rd_next         = hold_rd;
        hold_mem_to_reg_next = hold_mem_to_reg;
        case (state)
            mem_read_idle: begin
                if (mem_read) begin
                    // park the destination, send a bubble downstream
                    next_rd              = zero;
                    next_mem_to_reg      = 1'b0;
                    hold_rd_next         = mem_wb_in.rd;
                    hold_mem_to_reg_next = mem_wb_in.mem_to_reg;
                    state_next           = mem_reading;
                end
            end
            mem_reading: begin
                if (mem_ready) begin
                    // load data arrives with this cycle's input
                    next_rd         = hold_rd;
                    next_mem_to_reg = hold_mem_to_reg;
                    state_next      = mem_read_idle;
                end
            end
            default: state_next = mem_read_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state           <= mem_read_idle;
            hold_rd         <= zero;
            hold_mem_to_reg <= 1'b0;
            mem_wb_out      <= '0;
        end else begin
            state                 <= state_next;
            hold_rd               <= hold_rd_next;
            hold_mem_to_reg       <= hold_mem_to_reg_next;
            mem_wb_out.reg_write  <= mem_wb_in.reg_write;
            mem_wb_out.read_data  <= mem_wb_in.read_data;
            mem_wb_out.alu_out    <= mem_wb_in.alu_out;
            mem_wb_out.rd         <= next_rd;
            mem_wb_out.mem_to_reg <= next_mem_to_reg;
        end
    end

endmodule

//--- source/writeback_stage.sv
`timescale 1ns/100ps

module writeback_stage
    import definitions::*;
    import pipeline_pkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  mem_wb_t  mem_wb_out,
    output logic     rf_we,
    output regName_t rf_waddr,
    output word_t    rf_wdata,
    output commit_t  commit
);

    // load data or ALU result
    assign rf_wdata = mem_wb_out.mem_to_reg ? mem_wb_out.read_data : mem_wb_out.alu_out;
    assign rf_waddr = mem_wb_out.rd;

    // writes to x0 are dropped here and never show as commits
    assign rf_we = mem_wb_out.reg_write && (mem_wb_out.rd != zero);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            commit <= '0;
        end else begin
            commit <= '{valid: rf_we, rd: rf_waddr, data: rf_wdata};
        end
    end

endmodule

//--- source/register_file.sv
`timescale 1ns/100ps

module register_file
    import definitions::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  logic     rf_we,
    input  regName_t rf_waddr,
    input  word_t    rf_wdata,
    input  regName_t dbg_addr,
    output word_t    dbg_data
);

    // no storage behind x0
    word_t regs [1:31];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_we && (rf_waddr != zero)) begin
            regs[rf_waddr] <= rf_wdata;
        end
    end

    // combinational read, x0 reads zero
    assign dbg_data = (dbg_addr == zero) ? '0 : regs[dbg_addr];

endmodule

//--- source/mem_wb_top.sv
`timescale 1ns/100ps

module mem_wb_top
    import definitions::*;
    import pipeline_pkg::*;
#(
    parameter int MEM_DEPTH = 256,
    parameter int MEM_WAIT  = 3
)(
    input  logic     clk,
    input  logic     rstN,
    input  ex_mem_t  ex_in,
    input  regName_t dbg_addr,
    output logic     ex_ready,
    output commit_t  commit,
    output word_t    dbg_data
);

    // data memory handshake
    logic      dmem_req;
    logic      dmem_ack;
    dmem_req_t dmem_cmd;
    word_t     dmem_rdata;

    // memory stage to MEM/WB
    mem_wb_t   mem_wb_in;
    mem_wb_t   mem_wb_out;
    logic      mem_read;
    logic      mem_ready;

    // register file write port
    logic      rf_we;
    regName_t  rf_waddr;
    word_t     rf_wdata;

    mem_stage mem_stage0 (
        .clk        (clk),
        .rstN       (rstN),
        .ex_in      (ex_in),
        .dmem_ack   (dmem_ack),
        .dmem_rdata (dmem_rdata),
        .ex_ready   (ex_ready),
        .dmem_req   (dmem_req),
        .dmem_cmd   (dmem_cmd),
        .mem_wb_in  (mem_wb_in),
        .mem_read   (mem_read),
        .mem_ready  (mem_ready)
    );

    data_memory #(
        .MEM_DEPTH (MEM_DEPTH),
        .MEM_WAIT  (MEM_WAIT)
    ) data_memory0 (
        .clk        (clk),
        .rstN       (rstN),
        .dmem_req   (dmem_req),
        .dmem_cmd   (dmem_cmd),
        .dmem_ack   (dmem_ack),
        .dmem_rdata (dmem_rdata)
    );

    mem_wb_register mem_wb_register0 (
        .clk        (clk),
        .rstN       (rstN),
        .mem_wb_in  (mem_wb_in),
        .mem_read   (mem_read),
        .mem_ready  (mem_ready),
        .mem_wb_out (mem_wb_out)
    );

    writeback_stage writeback_stage0 (
        .clk        (clk),
        .rstN       (rstN),
        .mem_wb_out (mem_wb_out),
        .rf_we      (rf_we),
        .rf_waddr   (rf_waddr),
        .rf_wdata   (rf_wdata),
        .commit     (commit)
    );

    register_file register_file0 (
        .clk      (clk),
        .rstN     (rstN),
        .rf_we    (rf_we),
        .rf_waddr (rf_waddr),
        .rf_wdata (rf_wdata),
        .dbg_addr (dbg_addr),
        .dbg_data (dbg_data)
    );

endmodule

//--- verification/mem_wb_tb.sv
`timescale 1ns/100ps

module mem_wb_tb
    import definitions::*;
    import pipeline_pkg::*;
();

    localparam int TABLE_LEN = 20;
    localparam int MEM_DEPTH = 256;
    localparam int SLOW_WAIT = 3;
    localparam int FAST_WAIT = 0;
    // both passes over the table, two register sweeps, reset and drain
    localparam int TIMEOUT_CYCLES = TABLE_LEN * ((SLOW_WAIT + 6) + (FAST_WAIT + 6)) + 2 * 32 + 200;

    logic     clk;
    logic     rstN;
    logic     sel_fast;
    ex_mem_t  ex_drv;
    ex_mem_t  ex_slow;
    ex_mem_t  ex_fast;
    regName_t dbg_addr;
    logic     ready_slow;
    logic     ready_fast;
    logic     ex_ready;
    commit_t  commit_slow;
    commit_t  commit_fast;
    commit_t  commit;
    word_t    dbg_slow;
    word_t    dbg_fast;
    word_t    dbg_data;

    // stimulus with its expected commit per entry
    ex_mem_t     stim [TABLE_LEN];
    logic        exp_valid [TABLE_LEN];
    regName_t    exp_rd [TABLE_LEN];
    word_t       exp_data [TABLE_LEN];
    word_t       model_regs [32];
    word_t       model_mem [MEM_DEPTH];
    int          pending [$];
    int          head;
    int          errors;
    int          checks;
    int          cycles;
    logic [31:0] lfsr_state;

    // one DUT per memory wait setting and only the selected one sees traffic
    assign ex_slow  = sel_fast ? ex_mem_t'('0) : ex_drv;
    assign ex_fast  = sel_fast ? ex_drv : ex_mem_t'('0);
    assign ex_ready = sel_fast ? ready_fast : ready_slow;
    assign commit   = sel_fast ? commit_fast : commit_slow;
    assign dbg_data = sel_fast ? dbg_fast : dbg_slow;

    mem_wb_top #(.MEM_DEPTH(MEM_DEPTH), .MEM_WAIT(SLOW_WAIT)) dut0 (
        .clk      (clk),
        .rstN     (rstN),
        .ex_in    (ex_slow),
        .dbg_addr (dbg_addr),
        .ex_ready (ready_slow),
        .commit   (commit_slow),
        .dbg_data (dbg_slow)
    );

    mem_wb_top #(.MEM_DEPTH(MEM_DEPTH), .MEM_WAIT(FAST_WAIT)) dut1 (
        .clk      (clk),
        .rstN     (rstN),
        .ex_in    (ex_fast),
        .dbg_addr (dbg_addr),
        .ex_ready (ready_fast),
        .commit   (commit_fast),
        .dbg_data (dbg_fast)
    );

    always #5 clk = ~clk;

    // galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_word(output word_t w);
        w = '0;
        for (int b = 0; b < 32; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
    endtask

    function automatic ex_mem_t alu_entry(input regName_t rd, input word_t value, input logic wr);
        ex_mem_t e;
        e = '0;
        e.valid     = 1'b1;
        e.reg_write = wr;
        e.alu_out   = value;
        e.rd        = rd;
        return e;
    endfunction

    function automatic ex_mem_t store_entry(input addr_t addr, input word_t data);
        ex_mem_t e;
        e = '0;
        e.valid      = 1'b1;
        e.mem_write  = 1'b1;
        e.alu_out    = addr;
        e.store_data = data;
        return e;
    endfunction

    function automatic ex_mem_t load_entry(input regName_t rd, input addr_t addr);
        ex_mem_t e;
        e = '0;
        e.valid      = 1'b1;
        e.reg_write  = 1'b1;
        e.mem_to_reg = 1'b1;
        e.mem_read   = 1'b1;
        e.alu_out    = addr;
        e.rd         = rd;
        return e;
    endfunction

    task automatic build_table();
        word_t r [TABLE_LEN];
        for (int i = 0; i < TABLE_LEN; i++) begin
            random_word(r[i]);
        end
        stim[0]  = alu_entry(5'd1, r[0], 1'b1);
        stim[1]  = alu_entry(5'd2, r[1], 1'b1);
        stim[2]  = store_entry(32'h40, r[2]);
        stim[3]  = load_entry(5'd3, 32'h40);
        // never written so it reads back zero
        stim[4]  = load_entry(5'd4, 32'h80);
        stim[5]  = alu_entry(zero, r[5], 1'b1);
        stim[6]  = load_entry(zero, 32'h40);
        stim[7]  = store_entry(32'h44, r[7]);
        stim[8]  = alu_entry(5'd5, r[8], 1'b1);
        stim[9]  = load_entry(5'd6, 32'h44);
        stim[10] = alu_entry(5'd7, r[10], 1'b1);
        stim[11] = store_entry(32'h40, r[11]);
        stim[12] = load_entry(5'd1, 32'h40);
        stim[13] = alu_entry(5'd2, r[13], 1'b1);
        // 0x440 wraps onto the same word as 0x40
        stim[14] = store_entry(32'h440, r[14]);
        stim[15] = load_entry(5'd8, 32'h40);
        stim[16] = alu_entry(5'd31, r[16], 1'b1);
        stim[17] = load_entry(5'd9, 32'h7fc);
        stim[18] = alu_entry(5'd10, r[18], 1'b0);
        stim[19] = alu_entry(5'd3, r[19], 1'b1);
    endtask

    // reference model over the whole table in acceptance order
    task automatic build_expected();
        int idx;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < MEM_DEPTH; i++) begin
            model_mem[i] = '0;
        end
        for (int i = 0; i < TABLE_LEN; i++) begin
            idx          = int'((stim[i].alu_out >> 2) % MEM_DEPTH);
            exp_valid[i] = 1'b0;
            exp_rd[i]    = zero;
            exp_data[i]  = '0;
            if (stim[i].mem_write) begin
                model_mem[idx] = stim[i].store_data;
            end else if (stim[i].reg_write && stim[i].rd != zero) begin
                exp_valid[i] = 1'b1;
                exp_rd[i]    = stim[i].rd;
                exp_data[i]  = stim[i].mem_to_reg ? model_mem[idx] : stim[i].alu_out;
                model_regs[stim[i].rd] = exp_data[i];
            end
        end
    endtask

    task automatic run_table();
        logic prev_mem;
        prev_mem = 1'b0;
        @(posedge clk);
        ex_drv <= stim[0];
        for (int i = 0; i < TABLE_LEN; i++) begin
            @(negedge clk);
            assert (!(prev_mem && ex_ready)) else begin
                errors++;
                $display("error %0t ex_ready expected 0 got %b", $time, ex_ready);
            end
            while (!ex_ready) begin
                @(negedge clk);
            end
            // acceptance edge
            @(posedge clk);
            if (exp_valid[i]) begin
                pending.push_back(i);
            end
            prev_mem = stim[i].mem_read || stim[i].mem_write;
            ex_drv <= (i + 1 < TABLE_LEN) ? stim[i + 1] : ex_mem_t'('0);
        end
        while (pending.size() != 0) begin
            @(posedge clk);
        end
        // watch a little longer for late commits
        repeat (8) @(posedge clk);
    endtask

    task automatic check_registers();
        for (int r = 0; r < 32; r++) begin
            @(posedge clk);
            dbg_addr <= regName_t'(r);
            @(negedge clk);
            checks++;
            assert (dbg_data == model_regs[r]) else begin
                errors++;
                $display("error %0t dbg_data[x%0d] expected %h got %h",
                         $time, r, model_regs[r], dbg_data);
            end
        end
    endtask

    // each commit is compared against the oldest accepted instruction
    always @(negedge clk) begin
        if (rstN && commit.valid) begin
            assert (pending.size() != 0) else begin
                errors++;
                $display("commit to x%0d at %0t with no instruction waiting to retire",
                         commit.rd, $time);
            end
            if (pending.size() != 0) begin
                head = pending.pop_front();
                checks += 2;
                assert (commit.rd == exp_rd[head]) else begin
                    errors++;
                    $display("error %0t commit.rd expected x%0d got x%0d",
                             $time, exp_rd[head], commit.rd);
                end
                assert (commit.data == exp_data[head]) else begin
                    errors++;
                    $display("error %0t commit.data expected %h got %h",
                             $time, exp_data[head], commit.data);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("checks %0d errors %0d", checks, errors);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        clk        = 1'b0;
        rstN       = 1'b0;
        sel_fast   = 1'b0;
        ex_drv     = '0;
        dbg_addr   = zero;
        errors     = 0;
        checks     = 0;
        cycles     = 0;
        lfsr_state = 32'h4c8b_29db;
        build_table();
        build_expected();
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        // slow memory first and then the zero wait memory
        run_table();
        check_registers();
        @(posedge clk);
        sel_fast <= 1'b1;
        run_table();
        check_registers();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- build.f
common/definitions.sv
common/pipeline_pkg.sv
memory/mem_stage.sv
memory/data_memory.sv
source/mem_wb_register.sv
source/writeback_stage.sv
source/register_file.sv
source/mem_wb_top.sv
verification/mem_wb_tb.sv
